// File: idStage.f
rtl/idPkg.sv
rtl/instrDecoder.sv
rtl/operandFetch.sv
rtl/branchIssue.sv
rtl/idStage.sv
tests/idStageTb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module idStageTb \
	-f idStage.f -o idStageSim

simOutput=$(./obj_dir/idStageSim || true)
echo "$simOutput"

if echo "$simOutput" | grep -q "Finished with no errors"; then
	exit 0
else
	exit 1
fi

// File: tests/idStageTb.sv
// Testbench for the instruction decode stage
// Reference model of decode, forwarding and branch rules, checked every cycle
`timescale 1ns/1ps

module idStageTb;

	localparam int cycleLimit = 3000;   // About four times the stimulus length

	logic                         CLK;
	logic                         RESET;
	logic                         FREEZE;
	logic [idPkg::WORD_W-1:0]     instr;
	logic [idPkg::WORD_W-1:0]     pcNext;
	logic [idPkg::WORD_W-1:0]     exeResult;
	logic [idPkg::WORD_W-1:0]     memData;
	logic [idPkg::REG_ADDR_W-1:0] memReg;
	logic                         memWe;
	logic [idPkg::WORD_W-1:0]     wbData;
	logic [idPkg::REG_ADDR_W-1:0] wbReg;
	logic                         wbWe;
	logic [idPkg::WORD_W-1:0]     operandA;
	logic [idPkg::WORD_W-1:0]     operandB;
	logic [idPkg::REG_ADDR_W-1:0] writeReg;
	logic [idPkg::ALU_CTRL_W-1:0] aluControl;
	logic                         regWrite;
	logic                         memRead;
	logic                         memWrite;
	logic                         memToReg;
	logic                         aluSrc;
	logic                         takenBranch;
	logic [idPkg::WORD_W-1:0]     nextAddr;

	// Reference model state
	logic [idPkg::WORD_W-1:0]     modelRegs [idPkg::REG_COUNT];
	logic [idPkg::WORD_W-1:0]     expA;
	logic [idPkg::WORD_W-1:0]     expB;
	logic [idPkg::REG_ADDR_W-1:0] expWriteReg;
	logic [idPkg::ALU_CTRL_W-1:0] expAlu;
	logic                         expRegWrite;
	logic                         expMemRead;
	logic                         expMemWrite;
	logic                         expMemToReg;
	logic                         expAluSrc;
	logic                         expTaken;
	logic [idPkg::WORD_W-1:0]     expNext;
	logic                         modelStarted;
	logic                         frozeAtEdge;
	logic [112:0]                 heldOutputs;   // Outputs seen at the last check
	string                        testName;
	string                        expTest;
	int                           cycleCount;
	logic [5:0]                   rFuncList [13];
	logic [5:0]                   iOpList [7];

	int                           seedValue;
	int                           i;
	int                           cond;
	logic [2:0]                   combo;
	logic [idPkg::REG_ADDR_W-1:0] srcReg;
	logic [idPkg::REG_ADDR_W-1:0] otherReg;
	logic [idPkg::WORD_W-1:0]     valA;
	logic [idPkg::WORD_W-1:0]     valB;

	idStage i_dut (
		.CLK         (CLK),
		.RESET       (RESET),
		.FREEZE      (FREEZE),
		.instr       (instr),
		.pcNext      (pcNext),
		.exeResult   (exeResult),
		.memData     (memData),
		.memReg      (memReg),
		.memWe       (memWe),
		.wbData      (wbData),
		.wbReg       (wbReg),
		.wbWe        (wbWe),
		.operandA    (operandA),
		.operandB    (operandB),
		.writeReg    (writeReg),
		.aluControl  (aluControl),
		.regWrite    (regWrite),
		.memRead     (memRead),
		.memWrite    (memWrite),
		.memToReg    (memToReg),
		.aluSrc      (aluSrc),
		.takenBranch (takenBranch),
		.nextAddr    (nextAddr)
	);

	always #4 CLK = ~CLK;

	//////////////////////////////////////////////////////////////////////
	// Reference model

	// Newest pending result wins over the register array
	function automatic logic [idPkg::WORD_W-1:0] forwardedValue(
		input logic [idPkg::REG_ADDR_W-1:0] r
	);
		if (r == 5'd0)
			return '0;
		if (expRegWrite && (expWriteReg == r))
			return exeResult;   // Previous instruction, now in execute
		if (memWe && (memReg == r))
			return memData;
		if (wbWe && (wbReg == r))
			return wbData;
		return modelRegs[r];
	endfunction

	task automatic modelStep();
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  dest;
		logic [31:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		logic [5:0]  alu;
		logic        rw;
		logic        mr;
		logic        mw;
		logic        src;
		logic        br;
		logic        jmp;
		logic        jr;
		logic        lnk;
		logic        hit;
		op  = instr[31:26];
		fn  = instr[5:0];
		rs  = instr[25:21];
		rt  = instr[20:16];
		alu = '0;
		rw  = 1'b0;
		mr  = 1'b0;
		mw  = 1'b0;
		br  = 1'b0;
		jmp = 1'b0;
		jr  = 1'b0;
		lnk = 1'b0;
		hit = 1'b0;
		src = op inside {idPkg::OP_ADDI, idPkg::OP_ADDIU, idPkg::OP_SLTI, idPkg::OP_ANDI,
			idPkg::OP_ORI, idPkg::OP_XORI, idPkg::OP_LUI, idPkg::OP_LW, idPkg::OP_SW};
		imm = (op inside {idPkg::OP_ANDI, idPkg::OP_ORI, idPkg::OP_XORI}) ?
			{16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
		a = forwardedValue(rs);
		b = forwardedValue(rt);
		case (op)
			idPkg::OP_SPECIAL: begin
				rw = 1'b1;
				case (fn)
					idPkg::FN_SLL:  alu = idPkg::ALU_SLL;
					idPkg::FN_SRL:  alu = idPkg::ALU_SRL;
					idPkg::FN_SRA:  alu = idPkg::ALU_SRA;
					idPkg::FN_ADD:  alu = idPkg::ALU_ADD;
					idPkg::FN_ADDU: alu = idPkg::ALU_ADDU;
					idPkg::FN_SUB:  alu = idPkg::ALU_SUB;
					idPkg::FN_SUBU: alu = idPkg::ALU_SUBU;
					idPkg::FN_AND:  alu = idPkg::ALU_AND;
					idPkg::FN_OR:   alu = idPkg::ALU_OR;
					idPkg::FN_XOR:  alu = idPkg::ALU_XOR;
					idPkg::FN_NOR:  alu = idPkg::ALU_NOR;
					idPkg::FN_SLT:  alu = idPkg::ALU_SLT;
					idPkg::FN_SLTU: alu = idPkg::ALU_SLTU;
					idPkg::FN_JR: begin
						alu = idPkg::ALU_JR;
						rw  = 1'b0;
						jmp = 1'b1;
						jr  = 1'b1;
					end
					idPkg::FN_JALR: begin
						alu = idPkg::ALU_JALR;
						jmp = 1'b1;
						jr  = 1'b1;
						lnk = 1'b1;
					end
					default: rw = 1'b0;
				endcase
			end
			idPkg::OP_REGIMM: begin
				br  = (rt == idPkg::RT_BLTZ) || (rt == idPkg::RT_BGEZ);
				alu = (rt == idPkg::RT_BGEZ) ? idPkg::ALU_BGEZ : idPkg::ALU_BLTZ;
				hit = (rt == idPkg::RT_BGEZ) ? ($signed(a) >= 0) : ($signed(a) < 0);
				alu = br ? alu : '0;
			end
			idPkg::OP_J:     alu = idPkg::ALU_J;
			idPkg::OP_JAL:   alu = idPkg::ALU_JAL;
			idPkg::OP_BEQ:   alu = idPkg::ALU_BEQ;
			idPkg::OP_BNE:   alu = idPkg::ALU_BNE;
			idPkg::OP_BLEZ:  alu = idPkg::ALU_BLEZ;
			idPkg::OP_BGTZ:  alu = idPkg::ALU_BGTZ;
			idPkg::OP_ADDI:  alu = idPkg::ALU_ADDI;
			idPkg::OP_ADDIU: alu = idPkg::ALU_ADDIU;
			idPkg::OP_SLTI:  alu = idPkg::ALU_SLTI;
			idPkg::OP_ANDI:  alu = idPkg::ALU_ANDI;
			idPkg::OP_ORI:   alu = idPkg::ALU_ORI;
			idPkg::OP_XORI:  alu = idPkg::ALU_XORI;
			idPkg::OP_LUI:   alu = idPkg::ALU_LUI;
			idPkg::OP_LW:    alu = idPkg::ALU_LW;
			idPkg::OP_SW:    alu = idPkg::ALU_SW;
			default:         alu = '0;
		endcase
		if (op inside {idPkg::OP_BEQ, idPkg::OP_BNE, idPkg::OP_BLEZ, idPkg::OP_BGTZ})
			br = 1'b1;
		if (op == idPkg::OP_BEQ)
			hit = (a == b);
		if (op == idPkg::OP_BNE)
			hit = (a != b);
		if (op == idPkg::OP_BLEZ)
			hit = ($signed(a) <= 0);
		if (op == idPkg::OP_BGTZ)
			hit = ($signed(a) > 0);
		if (op inside {idPkg::OP_J, idPkg::OP_JAL})
			jmp = 1'b1;
		if (op == idPkg::OP_JAL)
			lnk = 1'b1;
		rw   = rw || lnk || (src && (op != idPkg::OP_SW));
		mr   = (op == idPkg::OP_LW);
		mw   = (op == idPkg::OP_SW);
		dest = lnk ? idPkg::LINK_REG : ((op == idPkg::OP_SPECIAL) ? instr[15:11] : rt);

		expA        = lnk ? pcNext : a;
		expB        = lnk ? idPkg::LINK_OFFSET : (src ? imm : b);
		expWriteReg = dest;
		expAlu      = alu;
		expRegWrite = rw && (dest != 5'd0);
		expMemRead  = mr;
		expMemWrite = mw;
		expMemToReg = mr;
		expAluSrc   = src;
		expTaken    = br && hit;
		if (jmp)
			expNext = jr ? a : {pcNext[31:28], instr[25:0], 2'b00};
		else
			expNext = (br && hit) ? pcNext + {imm[29:0], 2'b00} : pcNext;
	endtask

	always @(posedge CLK) begin
		if (!RESET) begin
			expA        = '0;
			expB        = '0;
			expWriteReg = '0;
			expAlu      = '0;
			expRegWrite = 1'b0;
			expMemRead  = 1'b0;
			expMemWrite = 1'b0;
			expMemToReg = 1'b0;
			expAluSrc   = 1'b0;
			expTaken    = 1'b0;
			expNext     = '0;
			frozeAtEdge = 1'b0;
		end else begin
			frozeAtEdge = FREEZE;
			if (!FREEZE)
				modelStep();
		end
		expTest      = testName;
		modelStarted = 1'b1;
	end

	// Register file writes land at the edge, also under freeze
	always @(posedge CLK) begin
		if (wbWe && (wbReg != 5'd0))
			modelRegs[wbReg] <= wbData;
	end

	//////////////////////////////////////////////////////////////////////
	// Checks, on the falling edge where outputs are stable

	function automatic logic [112:0] packOutputs();
		return {operandA, operandB, writeReg, aluControl, regWrite, memRead, memWrite,
			memToReg, aluSrc, takenBranch, nextAddr};
	endfunction

	task automatic compareOutput(input string sigName, input logic [31:0] expVal,
		input logic [31:0] actVal);
		assert (actVal === expVal) else begin
			$display("error in %s: %s expected %h, actual %h", expTest, sigName, expVal, actVal);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	always @(negedge CLK) begin
		if (modelStarted) begin
			compareOutput("operandA", expA, operandA);
			compareOutput("operandB", expB, operandB);
			compareOutput("writeReg", 32'(expWriteReg), 32'(writeReg));
			compareOutput("aluControl", 32'(expAlu), 32'(aluControl));
			compareOutput("regWrite", 32'(expRegWrite), 32'(regWrite));
			compareOutput("memRead", 32'(expMemRead), 32'(memRead));
			compareOutput("memWrite", 32'(expMemWrite), 32'(memWrite));
			compareOutput("memToReg", 32'(expMemToReg), 32'(memToReg));
			compareOutput("aluSrc", 32'(expAluSrc), 32'(aluSrc));
			compareOutput("takenBranch", 32'(expTaken), 32'(takenBranch));
			compareOutput("nextAddr", expNext, nextAddr);
			if (frozeAtEdge) begin
				assert (packOutputs() === heldOutputs) else begin
					$display("outputs changed while FREEZE was high in %s", expTest);
					$display("Finished with errors");
					$fatal(1);
				end
			end
			heldOutputs = packOutputs();
		end
	end

	always @(posedge CLK) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: stimulus did not finish within %0d cycles", cycleLimit);
			$display("Finished with errors");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers

	// Next falling edge, enables back to idle
	task automatic stepClock();
		@(negedge CLK);
		FREEZE    = 1'b0;
		memWe     = 1'b0;
		wbWe      = 1'b0;
		exeResult = $urandom;
	endtask

	function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {idPkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] randomAluInstr();
		logic [31:0] w;
		w = $urandom;
		if (w[31])
			return {idPkg::OP_SPECIAL, w[25:6], rFuncList[$urandom % 13]};
		return {iOpList[$urandom % 7], w[25:0]};
	endfunction

	function automatic logic [31:0] branchInstr(input int kind, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		case (kind)
			0:       return {idPkg::OP_BEQ, rs, rt, imm};
			1:       return {idPkg::OP_BNE, rs, rt, imm};
			2:       return {idPkg::OP_BLEZ, rs, 5'd0, imm};
			3:       return {idPkg::OP_BGTZ, rs, 5'd0, imm};
			4:       return {idPkg::OP_REGIMM, rs, idPkg::RT_BLTZ, imm};
			default: return {idPkg::OP_REGIMM, rs, idPkg::RT_BGEZ, imm};
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	initial begin
		seedValue    = $urandom(24);
		CLK          = 1'b0;
		RESET        = 1'b0;
		FREEZE       = 1'b0;
		instr        = '0;
		pcNext       = '0;
		exeResult    = '0;
		memData      = '0;
		memReg       = '0;
		memWe        = 1'b0;
		wbData       = '0;
		wbReg        = '0;
		wbWe         = 1'b0;
		modelStarted = 1'b0;
		cycleCount   = 0;
		testName     = "reset";
		rFuncList = '{idPkg::FN_SLL, idPkg::FN_SRL, idPkg::FN_SRA, idPkg::FN_ADD,
			idPkg::FN_ADDU, idPkg::FN_SUB, idPkg::FN_SUBU, idPkg::FN_AND, idPkg::FN_OR,
			idPkg::FN_XOR, idPkg::FN_NOR, idPkg::FN_SLT, idPkg::FN_SLTU};
		iOpList = '{idPkg::OP_ADDI, idPkg::OP_ADDIU, idPkg::OP_SLTI, idPkg::OP_ANDI,
			idPkg::OP_ORI, idPkg::OP_XORI, idPkg::OP_LUI};

		repeat (5) @(negedge CLK);
		RESET  = 1'b1;
		FREEZE = 1'b1;   // Zeros must survive the first cycle out of reset
		stepClock();

		// Instruction 0 reads only register 0 while the file fills
		testName = "registerFill";
		for (i = 1; i < idPkg::REG_COUNT; i++) begin
			stepClock();
			wbWe   = 1'b1;
			wbReg  = 5'(i);
			wbData = $urandom;
		end

		testName = "aluDecode";
		for (i = 0; i < 200; i++) begin
			stepClock();
			instr  = randomAluInstr();
			pcNext = $urandom & 32'hffff_fffc;
		end

		// Producer then consumer, pending sources chosen by combo
		testName = "forwarding";
		for (i = 0; i < 100; i++) begin
			combo    = 3'(i % 8);
			srcReg   = (i % 10 == 9) ? 5'd0 : 5'(1 + $urandom % 31);
			otherReg = (srcReg == 5'd31) ? 5'd1 : srcReg + 5'd1;
			stepClock();
			instr = rType(idPkg::FN_ADDU, otherReg, otherReg, combo[2] ? srcReg : otherReg);
			stepClock();
			memWe   = 1'b1;
			memReg  = combo[1] ? srcReg : otherReg;
			memData = $urandom;
			wbWe    = 1'b1;
			wbReg   = combo[0] ? srcReg : otherReg;
			wbData  = $urandom;
			instr   = rType(idPkg::FN_ADD, srcReg, (i % 2 == 1) ? srcReg : otherReg, 5'd9);
		end

		testName = "branches";
		for (cond = 0; cond < 6; cond++) begin
			for (i = 0; i < 30; i++) begin
				stepClock();
				srcReg   = 5'(1 + $urandom % 15);
				otherReg = 5'(16 + $urandom % 15);
				valB     = $urandom;
				case ($urandom % 4)
					0:       valA = '0;
					1:       valA = valB;
					2:       valA = $urandom;
					default: valA = $urandom | 32'h8000_0000;   // Negative
				endcase
				memWe   = 1'b1;
				memReg  = srcReg;
				memData = valA;
				wbWe    = 1'b1;
				wbReg   = otherReg;
				wbData  = valB;
				pcNext  = $urandom & 32'hffff_fffc;
				instr   = branchInstr(cond, srcReg, otherReg, 16'($urandom));
			end
		end

		testName = "jumpsLinks";
		for (i = 0; i < 40; i++) begin
			stepClock();
			pcNext  = $urandom & 32'hffff_fffc;
			memWe   = 1'b1;
			memReg  = 5'(1 + $urandom % 31);
			memData = $urandom & 32'hffff_fffc;
			case (i % 4)
				0:       instr = {idPkg::OP_J, 26'($urandom)};
				1:       instr = {idPkg::OP_JAL, 26'($urandom)};
				2:       instr = rType(idPkg::FN_JR, memReg, 5'd0, 5'd0);
				default: instr = rType(idPkg::FN_JALR, memReg, 5'd0, 5'd0);
			endcase
		end

		testName = "loadStore";
		for (i = 0; i < 30; i++) begin
			stepClock();
			instr = {(i % 2 == 1) ? idPkg::OP_SW : idPkg::OP_LW, 10'($urandom), 16'($urandom)};
		end

		// Reset again while the pipe register holds a store
		testName = "midReset";
		stepClock();
		RESET = 1'b0;
		repeat (5) stepClock();
		RESET  = 1'b1;
		FREEZE = 1'b1;

		// Inputs churn under freeze, writeback keeps filling registers 20 to 25
		testName = "freeze";
		stepClock();
		instr = {idPkg::OP_LW, 5'd3, 5'd7, 16'h0040};
		for (i = 0; i < 6; i++) begin
			stepClock();
			FREEZE = 1'b1;
			instr  = $urandom;
			pcNext = $urandom;
			wbWe   = 1'b1;
			wbReg  = 5'(20 + i);
			wbData = $urandom;
		end
		stepClock();
		instr = rType(idPkg::FN_OR, 5'd20, 5'd25, 5'd2);
		stepClock();
		instr = rType(idPkg::FN_AND, 5'd21, 5'd22, 5'd3);
		stepClock();
		stepClock();
		@(posedge CLK);
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: rtl/idStage.sv
// Instruction decode stage top level
// Decoder and operand fetch in parallel, feeding the branch and issue register
`timescale 1ns/1ps

module idStage (
	input  logic                            CLK,
	input  logic                            RESET,
	input  logic                            FREEZE,
	input  logic [idPkg::WORD_W-1:0]        instr,
	input  logic [idPkg::WORD_W-1:0]        pcNext,
	input  logic [idPkg::WORD_W-1:0]        exeResult,
	input  logic [idPkg::WORD_W-1:0]        memData,
	input  logic [idPkg::REG_ADDR_W-1:0]    memReg,
	input  logic                            memWe,
	input  logic [idPkg::WORD_W-1:0]        wbData,
	input  logic [idPkg::REG_ADDR_W-1:0]    wbReg,
	input  logic                            wbWe,
	output logic [idPkg::WORD_W-1:0]        operandA,
	output logic [idPkg::WORD_W-1:0]        operandB,
	output logic [idPkg::REG_ADDR_W-1:0]    writeReg,
	output logic [idPkg::ALU_CTRL_W-1:0]    aluControl,
	output logic                            regWrite,
	output logic                            memRead,
	output logic                            memWrite,
	output logic                            memToReg,
	output logic                            aluSrc,
	output logic                            takenBranch,
	output logic [idPkg::WORD_W-1:0]        nextAddr
);

	// Decoder outputs
	logic [idPkg::ALU_CTRL_W-1:0] decAluControl;
	logic                         decRegWrite;
	logic                         decMemRead;
	logic                         decMemWrite;
	logic                         decMemToReg;
	logic                         decAluSrc;
	logic                         isBranch;
	logic                         isJump;
	logic                         isJumpReg;
	logic                         isLink;
	logic [idPkg::REG_ADDR_W-1:0] decWriteReg;
	logic [idPkg::WORD_W-1:0]     immExt;

	// Forwarded sources
	logic [idPkg::WORD_W-1:0]     srcA;
	logic [idPkg::WORD_W-1:0]     srcB;

	instrDecoder i_decoder (
		.instr      (instr),
		.aluControl (decAluControl),
		.regWrite   (decRegWrite),
		.memRead    (decMemRead),
		.memWrite   (decMemWrite),
		.memToReg   (decMemToReg),
		.aluSrc     (decAluSrc),
		.isBranch   (isBranch),
		.isJump     (isJump),
		.isJumpReg  (isJumpReg),
		.isLink     (isLink),
		.writeReg   (decWriteReg),
		.immExt     (immExt)
	);

	// Execute-stage entry is this stage's own pipe register
	operandFetch i_operandFetch (
		.CLK       (CLK),
		.instr     (instr),
		.exeResult (exeResult),
		.exeReg    (writeReg),
		.exeWe     (regWrite),
		.memData   (memData),
		.memReg    (memReg),
		.memWe     (memWe),
		.wbData    (wbData),
		.wbReg     (wbReg),
		.wbWe      (wbWe),
		.srcA      (srcA),
		.srcB      (srcB)
	);

	branchIssue i_branchIssue (
		.CLK           (CLK),
		.RESET         (RESET),
		.FREEZE        (FREEZE),
		.instr         (instr),
		.pcNext        (pcNext),
		.srcA          (srcA),
		.srcB          (srcB),
		.immExt        (immExt),
		.decAluControl (decAluControl),
		.decRegWrite   (decRegWrite),
		.decMemRead    (decMemRead),
		.decMemWrite   (decMemWrite),
		.decMemToReg   (decMemToReg),
		.decAluSrc     (decAluSrc),
		.isBranch      (isBranch),
		.isJump        (isJump),
		.isJumpReg     (isJumpReg),
		.isLink        (isLink),
		.decWriteReg   (decWriteReg),
		.operandA      (operandA),
		.operandB      (operandB),
		.writeReg      (writeReg),
		.aluControl    (aluControl),
		.regWrite      (regWrite),
		.memRead       (memRead),
		.memWrite      (memWrite),
		.memToReg      (memToReg),
		.aluSrc        (aluSrc),
		.takenBranch   (takenBranch),
		.nextAddr      (nextAddr)
	);

endmodule

// File: rtl/branchIssue.sv
// Branch resolution and issue register
// Decides branches and jumps, builds the operands, holds the pipe register to execute
`timescale 1ns/1ps

module branchIssue (
	input  logic                            CLK,
	input  logic                            RESET,
	input  logic                            FREEZE,
	input  idPkg::instrWord_u               instr,
	input  logic [idPkg::WORD_W-1:0]        pcNext,
	input  logic [idPkg::WORD_W-1:0]        srcA,
	input  logic [idPkg::WORD_W-1:0]        srcB,
	input  logic [idPkg::WORD_W-1:0]        immExt,
	input  logic [idPkg::ALU_CTRL_W-1:0]    decAluControl,
	input  logic                            decRegWrite,
	input  logic                            decMemRead,
	input  logic                            decMemWrite,
	input  logic                            decMemToReg,
	input  logic                            decAluSrc,
	input  logic                            isBranch,
	input  logic                            isJump,
	input  logic                            isJumpReg,
	input  logic                            isLink,
	input  logic [idPkg::REG_ADDR_W-1:0]    decWriteReg,
	output logic [idPkg::WORD_W-1:0]        operandA,
	output logic [idPkg::WORD_W-1:0]        operandB,
	output logic [idPkg::REG_ADDR_W-1:0]    writeReg,
	output logic [idPkg::ALU_CTRL_W-1:0]    aluControl,
	output logic                            regWrite,
	output logic                            memRead,
	output logic                            memWrite,
	output logic                            memToReg,
	output logic                            aluSrc,
	output logic                            takenBranch,
	output logic [idPkg::WORD_W-1:0]        nextAddr
);

	logic                     branchCond;
	logic                     taken;
	logic [idPkg::WORD_W-1:0] branchTarget;
	logic [idPkg::WORD_W-1:0] jumpTarget;
	logic [idPkg::WORD_W-1:0] nextAddrD;

	//////////////////////////////////////////////////////////////////////
	// Branch condition on the forwarded sources
	always_comb begin
		case (instr.iFmt.opcode)
			idPkg::OP_BEQ:    branchCond = (srcA == srcB);
			idPkg::OP_BNE:    branchCond = (srcA != srcB);
			idPkg::OP_BLEZ:   branchCond = srcA[idPkg::WORD_W-1] || (srcA == '0);
			idPkg::OP_BGTZ:   branchCond = !srcA[idPkg::WORD_W-1] && (srcA != '0);
			idPkg::OP_REGIMM: branchCond = (instr.iFmt.rt == idPkg::RT_BGEZ) ?
				!srcA[idPkg::WORD_W-1] : srcA[idPkg::WORD_W-1];
			default:          branchCond = 1'b0;
		endcase
	end

	assign taken        = isBranch && branchCond;
	assign branchTarget = pcNext + (immExt << 2);

	// Register jumps take source A, the others stay in the current 256 MB region
	assign jumpTarget = isJumpReg ? srcA
		: {pcNext[idPkg::WORD_W-1 -: 4], instr.jFmt.index, 2'b00};

	assign nextAddrD = isJump ? jumpTarget : (taken ? branchTarget : pcNext);

	//////////////////////////////////////////////////////////////////////
	// Pipe register to execute
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			operandA    <= '0;
			operandB    <= '0;
			writeReg    <= '0;
			aluControl  <= '0;
			regWrite    <= 1'b0;
			memRead     <= 1'b0;
			memWrite    <= 1'b0;
			memToReg    <= 1'b0;
			aluSrc      <= 1'b0;
			takenBranch <= 1'b0;
			nextAddr    <= '0;
		end else if (!FREEZE) begin
			operandA    <= isLink ? pcNext : srcA;   // Link adds offset to return pc
			operandB    <= isLink ? idPkg::LINK_OFFSET : (decAluSrc ? immExt : srcB);
			writeReg    <= decWriteReg;
			aluControl  <= decAluControl;
			regWrite    <= decRegWrite && (decWriteReg != '0);
			memRead     <= decMemRead;
			memWrite    <= decMemWrite;
			memToReg    <= decMemToReg;
			aluSrc      <= decAluSrc;
			takenBranch <= taken;
			nextAddr    <= nextAddrD;
		end
	end

endmodule

// File: rtl/operandFetch.sv
// Operand fetch
// Register file with writeback port, forwarding from execute, memory and writeback
`timescale 1ns/1ps

module operandFetch (
	input  logic                            CLK,
	input  idPkg::instrWord_u               instr,
	input  logic [idPkg::WORD_W-1:0]        exeResult,
	input  logic [idPkg::REG_ADDR_W-1:0]    exeReg,
	input  logic                            exeWe,
	input  logic [idPkg::WORD_W-1:0]        memData,
	input  logic [idPkg::REG_ADDR_W-1:0]    memReg,
	input  logic                            memWe,
	input  logic [idPkg::WORD_W-1:0]        wbData,
	input  logic [idPkg::REG_ADDR_W-1:0]    wbReg,
	input  logic                            wbWe,
	output logic [idPkg::WORD_W-1:0]        srcA,
	output logic [idPkg::WORD_W-1:0]        srcB
);

	logic [idPkg::WORD_W-1:0] regFile [idPkg::REG_COUNT];

	//////////////////////////////////////////////////////////////////////
	// Register file, written at the edge and read combinationally
	always_ff @(posedge CLK) begin
		if (wbWe && (wbReg != '0))
			regFile[wbReg] <= wbData;
	end

	// Newest value wins, register 0 is hardwired
	function automatic logic [idPkg::WORD_W-1:0] fwdSelect(
		input logic [idPkg::REG_ADDR_W-1:0] src
	);
		if (src == '0)
			fwdSelect = '0;
		else if (exeWe && (exeReg == src))
			fwdSelect = exeResult;
		else if (memWe && (memReg == src))
			fwdSelect = memData;
		else if (wbWe && (wbReg == src))
			fwdSelect = wbData;   // Same-cycle write not yet in the array
		else
			fwdSelect = regFile[src];
	endfunction

	always_comb begin
		srcA = fwdSelect(instr.rFmt.rs);
		srcB = fwdSelect(instr.rFmt.rt);
	end

endmodule

// File: rtl/instrDecoder.sv
// Instruction decoder
// Control signals, ALU code, destination register and extended immediate
`timescale 1ns/1ps

module instrDecoder (
	input  idPkg::instrWord_u               instr,
	output logic [idPkg::ALU_CTRL_W-1:0]    aluControl,
	output logic                            regWrite,
	output logic                            memRead,
	output logic                            memWrite,
	output logic                            memToReg,
	output logic                            aluSrc,
	output logic                            isBranch,
	output logic                            isJump,
	output logic                            isJumpReg,
	output logic                            isLink,
	output logic [idPkg::REG_ADDR_W-1:0]    writeReg,
	output logic [idPkg::WORD_W-1:0]        immExt
);

	logic rAlu;     // SPECIAL arithmetic, logic or shift
	logic immAlu;   // Immediate arithmetic or logic
	logic zeroExt;

	assign immAlu = instr.iFmt.opcode inside {idPkg::OP_ADDI, idPkg::OP_ADDIU, idPkg::OP_SLTI,
		idPkg::OP_ANDI, idPkg::OP_ORI, idPkg::OP_XORI, idPkg::OP_LUI};

	// Logical immediates are unsigned
	assign zeroExt = instr.iFmt.opcode inside {idPkg::OP_ANDI, idPkg::OP_ORI, idPkg::OP_XORI};

	assign immExt = zeroExt ? {{(idPkg::WORD_W-16){1'b0}}, instr.iFmt.imm}
		: {{(idPkg::WORD_W-16){instr.iFmt.imm[15]}}, instr.iFmt.imm};

	assign writeReg = isLink ? idPkg::LINK_REG
		: (instr.rFmt.opcode == idPkg::OP_SPECIAL) ? instr.rFmt.rd : instr.iFmt.rt;

	always_comb begin
		aluControl = '0;
		regWrite   = 1'b0;
		memRead    = 1'b0;
		memWrite   = 1'b0;
		memToReg   = 1'b0;
		aluSrc     = 1'b0;
		isBranch   = 1'b0;
		isJump     = 1'b0;
		isJumpReg  = 1'b0;
		isLink     = 1'b0;
		rAlu       = 1'b0;
		case (instr.rFmt.opcode)
			idPkg::OP_SPECIAL: begin
				rAlu = 1'b1;
				case (instr.rFmt.funct)
					idPkg::FN_SLL:  aluControl = idPkg::ALU_SLL;
					idPkg::FN_SRL:  aluControl = idPkg::ALU_SRL;
					idPkg::FN_SRA:  aluControl = idPkg::ALU_SRA;
					idPkg::FN_ADD:  aluControl = idPkg::ALU_ADD;
					idPkg::FN_ADDU: aluControl = idPkg::ALU_ADDU;
					idPkg::FN_SUB:  aluControl = idPkg::ALU_SUB;
					idPkg::FN_SUBU: aluControl = idPkg::ALU_SUBU;
					idPkg::FN_AND:  aluControl = idPkg::ALU_AND;
					idPkg::FN_OR:   aluControl = idPkg::ALU_OR;
					idPkg::FN_XOR:  aluControl = idPkg::ALU_XOR;
					idPkg::FN_NOR:  aluControl = idPkg::ALU_NOR;
					idPkg::FN_SLT:  aluControl = idPkg::ALU_SLT;
					idPkg::FN_SLTU: aluControl = idPkg::ALU_SLTU;
					idPkg::FN_JR: begin
						aluControl = idPkg::ALU_JR;
						isJump     = 1'b1;
						isJumpReg  = 1'b1;
						rAlu       = 1'b0;
					end
					idPkg::FN_JALR: begin
						aluControl = idPkg::ALU_JALR;
						isJump     = 1'b1;
						isJumpReg  = 1'b1;
						isLink     = 1'b1;
						regWrite   = 1'b1;
						rAlu       = 1'b0;
					end
					default: rAlu = 1'b0;   // Unknown function code
				endcase
				regWrite = regWrite | rAlu;
			end
			idPkg::OP_REGIMM: begin
				if (instr.iFmt.rt == idPkg::RT_BLTZ) begin
					aluControl = idPkg::ALU_BLTZ;
					isBranch   = 1'b1;
				end else if (instr.iFmt.rt == idPkg::RT_BGEZ) begin
					aluControl = idPkg::ALU_BGEZ;
					isBranch   = 1'b1;
				end
			end
			idPkg::OP_J: begin
				aluControl = idPkg::ALU_J;
				isJump     = 1'b1;
			end
			idPkg::OP_JAL: begin
				aluControl = idPkg::ALU_JAL;
				isJump     = 1'b1;
				isLink     = 1'b1;
				regWrite   = 1'b1;
			end
			idPkg::OP_BEQ: begin
				aluControl = idPkg::ALU_BEQ;
				isBranch   = 1'b1;
			end
			idPkg::OP_BNE: begin
				aluControl = idPkg::ALU_BNE;
				isBranch   = 1'b1;
			end
			idPkg::OP_BLEZ: begin
				aluControl = idPkg::ALU_BLEZ;
				isBranch   = 1'b1;
			end
			idPkg::OP_BGTZ: begin
				aluControl = idPkg::ALU_BGTZ;
				isBranch   = 1'b1;
			end
			idPkg::OP_ADDI:  aluControl = idPkg::ALU_ADDI;
			idPkg::OP_ADDIU: aluControl = idPkg::ALU_ADDIU;
			idPkg::OP_SLTI:  aluControl = idPkg::ALU_SLTI;
			idPkg::OP_ANDI:  aluControl = idPkg::ALU_ANDI;
			idPkg::OP_ORI:   aluControl = idPkg::ALU_ORI;
			idPkg::OP_XORI:  aluControl = idPkg::ALU_XORI;
			idPkg::OP_LUI:   aluControl = idPkg::ALU_LUI;
			idPkg::OP_LW: begin
				aluControl = idPkg::ALU_LW;
				regWrite   = 1'b1;
				memRead    = 1'b1;
				memToReg   = 1'b1;
				aluSrc     = 1'b1;
			end
			idPkg::OP_SW: begin
				aluControl = idPkg::ALU_SW;
				memWrite   = 1'b1;
				aluSrc     = 1'b1;   // Address is base plus offset
			end
			default: ;
		endcase
		if (immAlu) begin
			regWrite = 1'b1;
			aluSrc   = 1'b1;
		end
	end

endmodule

// File: rtl/idPkg.sv
// Shared definitions for the instruction decode stage
// Widths, MIPS opcode and function codes, ALU control codes, instruction formats
package idPkg;

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int REG_COUNT  = 32;
	localparam int ALU_CTRL_W = 6;

	localparam logic [REG_ADDR_W-1:0] LINK_REG    = 5'd31;
	localparam logic [WORD_W-1:0]     LINK_OFFSET = 32'd4;   // Return address offset

	//////////////////////////////////////////////////////////////////////
	// Major opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_REGIMM  = 6'h01;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_BLEZ    = 6'h06;
	localparam logic [5:0] OP_BGTZ    = 6'h07;
	localparam logic [5:0] OP_ADDI    = 6'h08;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// SPECIAL function field
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	// REGIMM rt field
	localparam logic [REG_ADDR_W-1:0] RT_BLTZ = 5'h00;
	localparam logic [REG_ADDR_W-1:0] RT_BGEZ = 5'h01;

	//////////////////////////////////////////////////////////////////////
	// ALU control codes, as the execute stage expects them
	localparam logic [ALU_CTRL_W-1:0] ALU_SLL   = 6'b010011;
	localparam logic [ALU_CTRL_W-1:0] ALU_SRL   = 6'b011011;
	localparam logic [ALU_CTRL_W-1:0] ALU_SRA   = 6'b011001;
	localparam logic [ALU_CTRL_W-1:0] ALU_ADD   = 6'b000000;
	localparam logic [ALU_CTRL_W-1:0] ALU_ADDU  = 6'b110111;
	localparam logic [ALU_CTRL_W-1:0] ALU_SUB   = 6'b011101;
	localparam logic [ALU_CTRL_W-1:0] ALU_SUBU  = 6'b011110;
	localparam logic [ALU_CTRL_W-1:0] ALU_AND   = 6'b000100;
	localparam logic [ALU_CTRL_W-1:0] ALU_OR    = 6'b010000;
	localparam logic [ALU_CTRL_W-1:0] ALU_XOR   = 6'b011111;
	localparam logic [ALU_CTRL_W-1:0] ALU_NOR   = 6'b001111;
	localparam logic [ALU_CTRL_W-1:0] ALU_SLT   = 6'b010101;
	localparam logic [ALU_CTRL_W-1:0] ALU_SLTU  = 6'b111111;
	localparam logic [ALU_CTRL_W-1:0] ALU_ADDI  = 6'b000001;
	localparam logic [ALU_CTRL_W-1:0] ALU_ADDIU = 6'b000010;
	localparam logic [ALU_CTRL_W-1:0] ALU_SLTI  = ALU_SLT;
	localparam logic [ALU_CTRL_W-1:0] ALU_ANDI  = ALU_AND;
	localparam logic [ALU_CTRL_W-1:0] ALU_ORI   = ALU_OR;
	localparam logic [ALU_CTRL_W-1:0] ALU_XORI  = 6'b100000;
	localparam logic [ALU_CTRL_W-1:0] ALU_LUI   = 6'b001000;
	localparam logic [ALU_CTRL_W-1:0] ALU_LW    = 6'b111101;
	localparam logic [ALU_CTRL_W-1:0] ALU_SW    = 6'b110001;
	localparam logic [ALU_CTRL_W-1:0] ALU_BEQ   = 6'b100010;
	localparam logic [ALU_CTRL_W-1:0] ALU_BNE   = 6'b101001;
	localparam logic [ALU_CTRL_W-1:0] ALU_BLEZ  = 6'b100110;
	localparam logic [ALU_CTRL_W-1:0] ALU_BGTZ  = 6'b100101;
	localparam logic [ALU_CTRL_W-1:0] ALU_BLTZ  = 6'b100111;
	localparam logic [ALU_CTRL_W-1:0] ALU_BGEZ  = 6'b100011;
	localparam logic [ALU_CTRL_W-1:0] ALU_J     = 6'b001110;
	localparam logic [ALU_CTRL_W-1:0] ALU_JR    = 6'b111110;
	localparam logic [ALU_CTRL_W-1:0] ALU_JAL   = ALU_ADDI;    // Links compute pc plus offset
	localparam logic [ALU_CTRL_W-1:0] ALU_JALR  = ALU_ADDI;

	//////////////////////////////////////////////////////////////////////
	// One instruction word seen in its three formats
	typedef struct packed {
		logic [5:0]            opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [4:0]            shamt;
		logic [5:0]            funct;
	} rFields_s;

	typedef struct packed {
		logic [5:0]            opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [15:0]           imm;
	} iFields_s;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] index;
	} jFields_s;

	typedef union packed {
		rFields_s rFmt;
		iFields_s iFmt;
		jFields_s jFmt;
	} instrWord_u;

endpackage
